/* common/csr_consts.svh */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Data word and CSR address widths
`define CSR_XLEN   32
`define CSR_ADDR_W 12

// RV32 with A, I and M
// MXL=1 in bits 31:30, A is bit 0, I is bit 8, M is bit 12
`define CSR_MISA_VALUE 32'h4000_1101

// Synchronous causes
`define CSR_CAUSE_ECALL_U 32'd8
`define CSR_CAUSE_ECALL_M 32'd11

// Machine timer interrupt, interrupt flag plus code 7
`define CSR_CAUSE_M_TIMER 32'h8000_0007

// mstatus field positions
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MSTATUS_MPP_LSB  11

// Timer bit, same position in mie and mip
`define CSR_MIE_MTIE_BIT 7

// Operand value forced while a branch hazard squashes the command
// Gives address 0xfff, which decodes to nothing
`define CSR_SQUASH_DATA {`CSR_XLEN{1'b1}}

`endif

/* common/csr_pkg.sv */
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

    // CSR pipeline commands, encoding shared with the core decoder
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Only user and machine privilege exist here
    typedef enum logic [1:0] {
        MODE_USER    = 2'b00,
        MODE_MACHINE = 2'b11
    } priv_mode_e;

    typedef logic [`CSR_XLEN-1:0]   xlen_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // Implemented CSR addresses
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_ADDR_MSTATUS   = 12'h300,
        CSR_ADDR_MISA      = 12'h301,
        CSR_ADDR_MIE       = 12'h304,
        CSR_ADDR_MTVEC     = 12'h305,
        CSR_ADDR_MSCRATCH  = 12'h340,
        CSR_ADDR_MEPC      = 12'h341,
        CSR_ADDR_MCAUSE    = 12'h342,
        CSR_ADDR_MIP       = 12'h344,
        CSR_ADDR_CYCLE     = 12'hc00,
        CSR_ADDR_CYCLEH    = 12'hc80,
        CSR_ADDR_MVENDORID = 12'hf11,
        CSR_ADDR_MARCHID   = 12'hf12,
        CSR_ADDR_MIMPID    = 12'hf13,
        CSR_ADDR_MHARTID   = 12'hf14
    } csr_addr_e;

    // mcause layout, interrupt flag on top of the exception code
    typedef struct packed {
        logic        irq;
        logic [30:0] code;
    } cause_t;

endpackage

`default_nettype wire

/* common/csr_req_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface csr_req_if;
    import csr_pkg::*;

    // Current command, after the hazard squash
    csr_cmd_e  cmd;
    csr_addr_t addr;
    logic      rd_ok;

    // Write half of the read-modify-write, one cycle behind
    csr_cmd_e  wr_cmd;
    csr_addr_t wr_addr;
    xlen_t     wr_data;
    logic      wr_ok;

    modport dec (output cmd, addr, rd_ok, wr_cmd, wr_addr, wr_data, wr_ok);

    modport regs (input addr, rd_ok, wr_cmd, wr_addr, wr_data, wr_ok);

    modport res (input cmd, rd_ok);

endinterface

`default_nettype wire

/* common/trap_evt_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface trap_evt_if;
    import csr_pkg::*;

    // Event from trap control, at most one per cycle
    logic       take_irq;
    logic       take_ecall;
    logic       do_mret;
    cause_t     cause;
    xlen_t      epc;
    priv_mode_e cur_mode;

    // State returned by the register file
    xlen_t      mtvec;
    xlen_t      mepc;
    logic       mstatus_mie;
    logic       mstatus_mpie;
    priv_mode_e mstatus_mpp;
    logic       mie_mtie;

    modport ctrl (
        output take_irq, take_ecall, do_mret, cause, epc, cur_mode,
        input  mtvec, mepc, mstatus_mie, mstatus_mpie, mstatus_mpp, mie_mtie
    );

    modport regs (
        input  take_irq, take_ecall, do_mret, cause, epc, cur_mode,
        output mtvec, mepc, mstatus_mie, mstatus_mpie, mstatus_mpp, mie_mtie
    );

endinterface

`default_nettype wire

/* source/csr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                wb_branch_hazard,
    input  csr_pkg::csr_cmd_e   cmd,
    input  csr_pkg::xlen_t      op1_data,
    input  csr_pkg::xlen_t      imm_i,
    input  csr_pkg::priv_mode_e mode,
    csr_req_if.dec              req
);
    import csr_pkg::*;

    xlen_t op1_sq;
    xlen_t imm_sq;

    // Squash on a branch hazard
    // Command becomes a no-op with all-ones operands
    assign req.cmd = wb_branch_hazard ? CSR_X : cmd;
    assign op1_sq  = wb_branch_hazard ? `CSR_SQUASH_DATA : op1_data;
    assign imm_sq  = wb_branch_hazard ? `CSR_SQUASH_DATA : imm_i;

    // CSR number sits in the I-type immediate
    assign req.addr = imm_sq[`CSR_ADDR_W-1:0];

    // Bits 9:8 give the lowest privilege allowed
    assign req.rd_ok = (req.addr[9:8] <= mode);

    // Control state of the write half
    // Permission is taken with the mode of the issuing cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req.wr_cmd <= CSR_X;
            req.wr_ok  <= 1'b0;
        end else begin
            req.wr_cmd <= req.cmd;
            // Bits 11:10 both set mark a read-only CSR
            req.wr_ok  <= req.rd_ok && (req.addr[11:10] != 2'b11);
        end
    end

    // Address and operand held for the next cycle
    always_ff @(posedge clk) begin
        req.wr_addr <= req.addr;
        req.wr_data <= op1_sq;
    end

    // Squashed command reaches the write half as a no-op without permission
    a_squash_is_nop: assert property (@(posedge clk) disable iff (!arst_n)
        wb_branch_hazard |=> (req.wr_cmd == CSR_X) && !req.wr_ok);

endmodule

`default_nettype wire

/* csr_file/csr_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_regs (
    input  logic           clk,
    input  logic           arst_n,
    input  logic [63:0]    reg_cycle,
    input  logic           timer_pending,
    csr_req_if.regs        req,
    trap_evt_if.regs       trap,
    output csr_pkg::xlen_t rd_value
);
    import csr_pkg::*;

    xlen_t mscratch;
    xlen_t mcause;
    xlen_t rd_prev;
    xlen_t wdata;
    xlen_t mstatus_rd;
    xlen_t mie_rd;
    xlen_t mip_rd;
    logic  wr_en;

    // Packed views of the bit-field registers
    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[`CSR_MSTATUS_MIE_BIT]  = trap.mstatus_mie;
        mstatus_rd[`CSR_MSTATUS_MPIE_BIT] = trap.mstatus_mpie;
        mstatus_rd[`CSR_MSTATUS_MPP_LSB +: 2] = trap.mstatus_mpp;
        mie_rd = '0;
        mie_rd[`CSR_MIE_MTIE_BIT] = trap.mie_mtie;
        mip_rd = '0;
        mip_rd[`CSR_MIE_MTIE_BIT] = timer_pending;
    end

    // Read mux on the current address
    always_comb begin
        case (req.addr)
            CSR_ADDR_MSTATUS:   rd_value = mstatus_rd;
            CSR_ADDR_MISA:      rd_value = `CSR_MISA_VALUE;
            CSR_ADDR_MIE:       rd_value = mie_rd;
            CSR_ADDR_MTVEC:     rd_value = trap.mtvec;
            CSR_ADDR_MSCRATCH:  rd_value = mscratch;
            CSR_ADDR_MEPC:      rd_value = trap.mepc;
            CSR_ADDR_MCAUSE:    rd_value = mcause;
            CSR_ADDR_MIP:       rd_value = mip_rd;
            CSR_ADDR_CYCLE:     rd_value = reg_cycle[31:0];
            CSR_ADDR_CYCLEH:    rd_value = reg_cycle[63:32];
            // ID registers read as zero
            CSR_ADDR_MVENDORID: rd_value = '0;
            CSR_ADDR_MARCHID:   rd_value = '0;
            CSR_ADDR_MIMPID:    rd_value = '0;
            CSR_ADDR_MHARTID:   rd_value = '0;
            default:            rd_value = '0;
        endcase
    end

    // Copy of the read data as the result stage sees it
    always_ff @(posedge clk) begin
        rd_prev <= req.rd_ok ? rd_value : '0;
    end

    // Second half of the read-modify-write
    always_comb begin
        case (req.wr_cmd)
            CSR_W:   wdata = req.wr_data;
            CSR_S:   wdata = rd_prev | req.wr_data;
            CSR_C:   wdata = rd_prev & ~req.wr_data;
            default: wdata = rd_prev;
        endcase
    end

    assign wr_en = req.wr_ok &&
                   (req.wr_cmd == CSR_W || req.wr_cmd == CSR_S || req.wr_cmd == CSR_C);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            trap.mstatus_mie  <= 1'b0;
            trap.mstatus_mpie <= 1'b0;
            trap.mstatus_mpp  <= MODE_MACHINE;
            trap.mie_mtie     <= 1'b0;
            trap.mtvec        <= '0;
            trap.mepc         <= '0;
            mscratch          <= '0;
            mcause            <= '0;
        end else begin
            if (wr_en) begin
                case (req.wr_addr)
                    CSR_ADDR_MSTATUS: begin
                        trap.mstatus_mie  <= wdata[`CSR_MSTATUS_MIE_BIT];
                        trap.mstatus_mpie <= wdata[`CSR_MSTATUS_MPIE_BIT];
                        // MPP is WARL, anything but machine falls back to user
                        trap.mstatus_mpp  <= (wdata[`CSR_MSTATUS_MPP_LSB +: 2] == 2'b11) ?
                                             MODE_MACHINE : MODE_USER;
                    end
                    CSR_ADDR_MIE:      trap.mie_mtie <= wdata[`CSR_MIE_MTIE_BIT];
                    CSR_ADDR_MTVEC:    trap.mtvec    <= wdata;
                    CSR_ADDR_MSCRATCH: mscratch      <= wdata;
                    // Instructions are word aligned
                    CSR_ADDR_MEPC:     trap.mepc     <= {wdata[`CSR_XLEN-1:2], 2'b00};
                    CSR_ADDR_MCAUSE:   mcause        <= wdata;
                    // misa, mip, counters and IDs stay as they are
                    default: begin
                    end
                endcase
            end

            // Trap updates come last and win over the write
            if (trap.take_irq) begin
                mcause            <= trap.cause;
                trap.mepc         <= trap.epc;
                trap.mstatus_mpp  <= trap.cur_mode;
                trap.mstatus_mpie <= trap.mstatus_mie;
                trap.mstatus_mie  <= 1'b0;
            end else if (trap.take_ecall) begin
                mcause <= trap.cause;
            end else if (trap.do_mret) begin
                trap.mstatus_mpp <= MODE_USER;
                trap.mstatus_mie <= trap.mstatus_mpie;
            end
        end
    end

    // Trap control issues one event at a time
    a_one_event: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({trap.take_irq, trap.take_ecall, trap.do_mret}));

endmodule

`default_nettype wire

/* csr_file/trap_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module trap_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  csr_pkg::csr_cmd_e   cmd,
    input  logic [63:0]         mtime,
    input  logic [63:0]         mtimecmp,
    input  logic                interrupt_ready,
    input  csr_pkg::xlen_t      fetch_pc,
    trap_evt_if.ctrl            trap,
    output csr_pkg::priv_mode_e mode,
    output logic                timer_pending,
    output csr_pkg::xlen_t      trap_vector_next,
    output logic                trap_taken
);
    import csr_pkg::*;

    logic  timer_hit;
    xlen_t mtvec_base;
    xlen_t vec_offset;

    // Interrupt wins over the command in the same cycle
    assign trap.take_irq   = timer_pending && interrupt_ready;
    assign trap.take_ecall = !trap.take_irq && (cmd == CSR_ECALL);
    assign trap.do_mret    = !trap.take_irq && (cmd == CSR_MRET);
    assign trap_taken      = trap.take_irq;

    always_comb begin
        if (trap.take_irq) begin
            trap.cause = `CSR_CAUSE_M_TIMER;
        end else if (mode == MODE_USER) begin
            trap.cause = `CSR_CAUSE_ECALL_U;
        end else begin
            trap.cause = `CSR_CAUSE_ECALL_M;
        end
    end

    assign trap.epc      = fetch_pc;
    assign trap.cur_mode = mode;

    // mtvec mode 0 is direct, otherwise vectored
    // Synchronous causes still land on the base
    assign mtvec_base = {trap.mtvec[`CSR_XLEN-1:2], 2'b00};
    assign vec_offset = trap.cause.irq ? {trap.cause.code[29:0], 2'b00} : '0;

    always_comb begin
        if (trap.do_mret) begin
            trap_vector_next = trap.mepc;
        end else if (trap.mtvec[1:0] == 2'b00) begin
            trap_vector_next = trap.mtvec;
        end else begin
            trap_vector_next = mtvec_base + vec_offset;
        end
    end

    // Timer compare gated by the global and timer enables
    assign timer_hit = trap.mstatus_mie && trap.mie_mtie && (mtime >= mtimecmp);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode          <= MODE_MACHINE;
            timer_pending <= 1'b0;
        end else begin
            // MIE drops on the trap edge, so MTIP drops with it
            timer_pending <= trap.take_irq ? 1'b0 : timer_hit;
            if (trap.take_irq || trap.take_ecall) begin
                mode <= MODE_MACHINE;
            end else if (trap.do_mret) begin
                mode <= trap.mstatus_mpp;
            end
        end
    end

    // MRET takes MPP, which the register file keeps legal
    a_mode_legal: assert property (@(posedge clk) disable iff (!arst_n)
        mode == MODE_USER || mode == MODE_MACHINE);

    // Interrupt entry stacks MIE into MPIE
    a_irq_stack: assert property (@(posedge clk) disable iff (!arst_n)
        trap.take_irq |=> !trap.mstatus_mie && (trap.mstatus_mpie == $past(trap.mstatus_mie)));

endmodule

`default_nettype wire

/* source/csr_result.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_result (
    input  logic              clk,
    input  logic              arst_n,
    csr_req_if.res            req,
    input  csr_pkg::xlen_t    rd_value,
    input  logic              trap_taken,
    input  csr_pkg::xlen_t    trap_vector_next,
    output csr_pkg::csr_cmd_e cmd_out,
    output csr_pkg::xlen_t    rdata,
    output csr_pkg::xlen_t    trap_vector
);
    import csr_pkg::*;

    logic redirect;

    // Any event that sends the fetch to a new PC
    assign redirect = trap_taken || (req.cmd == CSR_ECALL) || (req.cmd == CSR_MRET);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_out     <= CSR_X;
            rdata       <= '0;
            trap_vector <= '0;
        end else begin
            // Interrupt shows up downstream as an ECALL
            cmd_out <= trap_taken ? CSR_ECALL : req.cmd;
            // Zero without permission
            rdata   <= req.rd_ok ? rd_value : '0;
            if (redirect) begin
                trap_vector <= trap_vector_next;
            end
        end
    end

endmodule

`default_nettype wire

/* source/csr_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [63:0]       reg_cycle,
    input  logic [63:0]       mtime,
    input  logic [63:0]       mtimecmp,
    input  logic              wb_branch_hazard,
    input  csr_pkg::csr_cmd_e cmd,
    input  csr_pkg::xlen_t    op1_data,
    input  csr_pkg::xlen_t    imm_i,
    input  logic              interrupt_ready,
    input  csr_pkg::xlen_t    fetch_pc,
    output csr_pkg::csr_cmd_e csr_cmd_out,
    output csr_pkg::xlen_t    csr_rdata,
    output csr_pkg::xlen_t    trap_vector,
    output logic              stall_may_interrupt
);
    import csr_pkg::*;

    priv_mode_e mode;
    xlen_t      rd_value;
    xlen_t      trap_vector_next;
    logic       trap_taken;

    csr_req_if  req_if ();
    trap_evt_if trap_if ();

    csr_decode decode_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .wb_branch_hazard (wb_branch_hazard),
        .cmd              (cmd),
        .op1_data         (op1_data),
        .imm_i            (imm_i),
        .mode             (mode),
        .req              (req_if.dec)
    );

    // MTIP doubles as the stall request
    csr_regs regs_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .reg_cycle     (reg_cycle),
        .timer_pending (stall_may_interrupt),
        .req           (req_if.regs),
        .trap          (trap_if.regs),
        .rd_value      (rd_value)
    );

    trap_ctrl trap_ctrl_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .cmd              (req_if.cmd),
        .mtime            (mtime),
        .mtimecmp         (mtimecmp),
        .interrupt_ready  (interrupt_ready),
        .fetch_pc         (fetch_pc),
        .trap             (trap_if.ctrl),
        .mode             (mode),
        .timer_pending    (stall_may_interrupt),
        .trap_vector_next (trap_vector_next),
        .trap_taken       (trap_taken)
    );

    csr_result result_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .req              (req_if.res),
        .rd_value         (rd_value),
        .trap_taken       (trap_taken),
        .trap_vector_next (trap_vector_next),
        .cmd_out          (csr_cmd_out),
        .rdata            (csr_rdata),
        .trap_vector      (trap_vector)
    );

endmodule

`default_nettype wire

/* verif/tb_csr_checks.svh */
`ifndef TB_CSR_CHECKS_SVH
`define TB_CSR_CHECKS_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'h5017_f983;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

// One LFSR step per bit taken, first bit lands on top
function automatic xlen_t rand_bits(input int n);
    xlen_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// Command seen downstream, one cycle after the DUT sampled it
a_cmd_out: assert property (@(posedge clk) disable iff (!arst_n)
    chk_d |-> csr_cmd_out == exp_cmd_d)
    else begin
        err_count++;
        $display("FAILED %0t csr_cmd_out got %0d expected %0d",
                 $time, $sampled(csr_cmd_out), $sampled(exp_cmd_d));
    end

// Read data against the model
a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
    chk_d |-> csr_rdata == exp_rd_d)
    else begin
        err_count++;
        $display("FAILED %0t csr_rdata got %h expected %h",
                 $time, $sampled(csr_rdata), $sampled(exp_rd_d));
    end

// Redirect target on trap, ECALL and MRET
a_trap_vector: assert property (@(posedge clk) disable iff (!arst_n)
    chk_tv_d |-> trap_vector == exp_tv_d)
    else begin
        err_count++;
        $display("FAILED %0t trap_vector got %h expected %h",
                 $time, $sampled(trap_vector), $sampled(exp_tv_d));
    end

// No stall request while the timer is not armed
a_stall_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    !irq_armed |-> !stall_may_interrupt)
    else begin
        err_count++;
        $display("FAILED %0t stall_may_interrupt got %b expected 0",
                 $time, $sampled(stall_may_interrupt));
    end

`endif

/* verif/tb_csr_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module tb_csr_stage;
    import csr_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    // Upper bound on commands over all tests, two cycles each
    localparam int MAX_CMDS     = 50;
    localparam int NUM_TESTS    = 7;
    localparam int MTIP_WAIT    = 10;
    localparam int RUN_CYCLES   = RESET_CYCLES + 2 * MAX_CMDS + 3 * NUM_TESTS + MTIP_WAIT;
    localparam int MARGIN_NS    = 1000;

    logic        clk;
    logic        arst_n;
    logic [63:0] reg_cycle;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        wb_branch_hazard;
    csr_cmd_e    cmd;
    xlen_t       op1_data;
    xlen_t       imm_i;
    logic        interrupt_ready;
    xlen_t       fetch_pc;
    csr_cmd_e    csr_cmd_out;
    xlen_t       csr_rdata;
    xlen_t       trap_vector;
    logic        stall_may_interrupt;

    // Expected results, set with the command, shifted once
    logic     chk_q, chk_d;
    logic     chk_tv_q, chk_tv_d;
    csr_cmd_e exp_cmd_q, exp_cmd_d;
    xlen_t    exp_rd_q, exp_rd_d;
    xlen_t    exp_tv_q, exp_tv_d;
    logic     irq_armed;

    // Side inputs for the next command
    logic  tv_chk_next;
    xlen_t tv_val_next;
    logic  haz_next;
    logic  ready_next;

    // Reference model
    xlen_t      m_mscratch;
    xlen_t      m_mtvec;
    xlen_t      m_mepc;
    xlen_t      m_mcause;
    priv_mode_e m_mode;
    priv_mode_e m_mpp;
    logic       m_mie;
    logic       m_mpie;

    int    err_count;
    int    check_count;
    int    test_count;
    int    test_errs;
    string test_name;

    `include "tb_csr_checks.svh"

    csr_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        chk_d     <= chk_q;
        chk_tv_d  <= chk_tv_q;
        exp_cmd_d <= exp_cmd_q;
        exp_rd_d  <= exp_rd_q;
        exp_tv_d  <= exp_tv_q;
    end

    // CSR instruction semantics for W, S and C
    function automatic xlen_t rmw(input csr_cmd_e c, input xlen_t old, input xlen_t d);
        case (c)
            CSR_S:   return old | d;
            CSR_C:   return old & ~d;
            default: return d;
        endcase
    endfunction

    function automatic xlen_t mstatus_model();
        xlen_t v;
        v = '0;
        v[`CSR_MSTATUS_MIE_BIT]       = m_mie;
        v[`CSR_MSTATUS_MPIE_BIT]      = m_mpie;
        v[`CSR_MSTATUS_MPP_LSB +: 2]  = m_mpp;
        return v;
    endfunction

    task automatic expect_tv(input xlen_t v);
        tv_chk_next = 1'b1;
        tv_val_next = v;
    endtask

    // One command, then an idle cycle
    task automatic send_cmd(input csr_cmd_e c, input logic [11:0] a, input xlen_t d,
                            input csr_cmd_e e_cmd, input xlen_t e_rd);
        @(posedge clk);
        cmd              <= c;
        imm_i            <= {20'd0, a};
        op1_data         <= d;
        wb_branch_hazard <= haz_next;
        interrupt_ready  <= ready_next;
        chk_q            <= 1'b1;
        chk_tv_q         <= tv_chk_next;
        exp_cmd_q        <= e_cmd;
        exp_rd_q         <= e_rd;
        exp_tv_q         <= tv_val_next;
        check_count++;
        tv_chk_next = 1'b0;
        haz_next    = 1'b0;
        ready_next  = 1'b0;
        @(posedge clk);
        cmd              <= CSR_X;
        wb_branch_hazard <= 1'b0;
        interrupt_ready  <= 1'b0;
        chk_q            <= 1'b0;
        chk_tv_q         <= 1'b0;
    endtask

    // csrrs with a zero operand
    task automatic read_csr(input logic [11:0] a, input xlen_t e_rd);
        send_cmd(CSR_S, a, '0, CSR_S, e_rd);
    endtask

    task automatic wait_mtip();
        int n;
        n = 0;
        @(negedge clk);
        while (!stall_may_interrupt && n < MTIP_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!stall_may_interrupt) begin
            err_count++;
            $display("stall_may_interrupt did not rise within %0d cycles at %0t",
                     MTIP_WAIT, $time);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = err_count;
    endtask

    // Last check lands one edge after the idle cycle
    task automatic end_test();
        repeat (2) @(posedge clk);
        test_count++;
        if (err_count == test_errs) begin
            $display("test %s passed", test_name);
        end else begin
            $display("test %s failed with %0d errors", test_name, err_count - test_errs);
        end
    endtask

    initial begin
        xlen_t       data;
        xlen_t       r;
        xlen_t       base;
        xlen_t       pc;
        csr_cmd_e    c;
        logic [63:0] cyc;

        arst_n           <= 1'b0;
        reg_cycle        <= '0;
        mtime            <= '0;
        mtimecmp         <= 64'h0000_0000_0001_0000;
        wb_branch_hazard <= 1'b0;
        cmd              <= CSR_X;
        op1_data         <= '0;
        imm_i            <= '0;
        interrupt_ready  <= 1'b0;
        fetch_pc         <= '0;
        chk_q            <= 1'b0;
        chk_tv_q         <= 1'b0;
        exp_cmd_q        <= CSR_X;
        exp_rd_q         <= '0;
        exp_tv_q         <= '0;
        irq_armed        <= 1'b0;
        tv_chk_next = 1'b0;
        tv_val_next = '0;
        haz_next    = 1'b0;
        ready_next  = 1'b0;
        m_mscratch  = '0;
        m_mtvec     = '0;
        m_mepc      = '0;
        m_mcause    = '0;
        m_mode      = MODE_MACHINE;
        m_mpp       = MODE_MACHINE;
        m_mie       = 1'b0;
        m_mpie      = 1'b0;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        // Outputs still at their reset values
        begin_test("reset");
        expect_tv('0);
        send_cmd(CSR_X, 12'h000, '0, CSR_X, '0);
        end_test();

        // Random W, S and C, each returns the old value
        begin_test("rw");
        for (int i = 0; i < 16; i++) begin
            r    = rand_bits(3);
            data = rand_bits(32);
            c    = (r[2:1] == 2'd1) ? CSR_S : (r[2:1] == 2'd2) ? CSR_C : CSR_W;
            if (r[0]) begin
                send_cmd(c, CSR_ADDR_MTVEC, data, c, m_mtvec);
                m_mtvec = rmw(c, m_mtvec, data);
            end else begin
                send_cmd(c, CSR_ADDR_MSCRATCH, data, c, m_mscratch);
                m_mscratch = rmw(c, m_mscratch, data);
            end
        end
        read_csr(CSR_ADDR_MSCRATCH, m_mscratch);
        read_csr(CSR_ADDR_MTVEC, m_mtvec);
        end_test();

        begin_test("const");
        cyc = {rand_bits(32), rand_bits(32)};
        @(posedge clk);
        reg_cycle <= cyc;
        read_csr(CSR_ADDR_MISA, `CSR_MISA_VALUE);
        send_cmd(CSR_W, CSR_ADDR_MISA, rand_bits(32), CSR_W, `CSR_MISA_VALUE);
        read_csr(CSR_ADDR_MISA, `CSR_MISA_VALUE);
        read_csr(CSR_ADDR_MVENDORID, '0);
        read_csr(CSR_ADDR_CYCLE, cyc[31:0]);
        read_csr(CSR_ADDR_CYCLEH, cyc[63:32]);
        end_test();

        // Direct mtvec, then back out through MRET into user mode
        begin_test("ecall");
        data = rand_bits(32) & 32'hffff_fffc;
        send_cmd(CSR_W, CSR_ADDR_MTVEC, data, CSR_W, m_mtvec);
        m_mtvec = data;
        expect_tv(m_mtvec);
        send_cmd(CSR_ECALL, 12'h000, '0, CSR_ECALL, '0);
        m_mcause = `CSR_CAUSE_ECALL_M;
        read_csr(CSR_ADDR_MCAUSE, m_mcause);
        data = rand_bits(32);
        send_cmd(CSR_W, CSR_ADDR_MEPC, data, CSR_W, m_mepc);
        m_mepc = data & 32'hffff_fffc;
        send_cmd(CSR_C, CSR_ADDR_MSTATUS, 32'h0000_1800, CSR_C, mstatus_model());
        m_mpp = MODE_USER;
        expect_tv(m_mepc);
        send_cmd(CSR_MRET, 12'h000, '0, CSR_MRET, '0);
        m_mode = m_mpp;
        m_mie  = m_mpie;
        m_mpp  = MODE_USER;
        end_test();

        // Machine CSRs hidden from user mode
        begin_test("user");
        read_csr(CSR_ADDR_MSCRATCH, '0);
        send_cmd(CSR_W, CSR_ADDR_MSCRATCH, rand_bits(32), CSR_W, '0);
        expect_tv(m_mtvec);
        send_cmd(CSR_ECALL, 12'h000, '0, CSR_ECALL, '0);
        m_mcause = `CSR_CAUSE_ECALL_U;
        m_mode   = MODE_MACHINE;
        read_csr(CSR_ADDR_MSCRATCH, m_mscratch);
        read_csr(CSR_ADDR_MCAUSE, m_mcause);
        end_test();

        begin_test("squash");
        haz_next = 1'b1;
        send_cmd(CSR_W, CSR_ADDR_MSCRATCH, rand_bits(32), CSR_X, '0);
        read_csr(CSR_ADDR_MSCRATCH, m_mscratch);
        end_test();

        // Vectored mtvec, timer cause 7 lands at base plus 28
        begin_test("timer");
        base = rand_bits(32) & 32'hffff_ff00;
        pc   = rand_bits(32) & 32'hffff_fffc;
        send_cmd(CSR_W, CSR_ADDR_MTVEC, base | 32'h1, CSR_W, m_mtvec);
        m_mtvec = base | 32'h1;
        send_cmd(CSR_S, CSR_ADDR_MSTATUS, 32'h8, CSR_S, mstatus_model());
        m_mie = 1'b1;
        send_cmd(CSR_S, CSR_ADDR_MIE, 32'h80, CSR_S, '0);
        @(posedge clk);
        mtime     <= mtimecmp + 64'd5;
        fetch_pc  <= pc;
        irq_armed <= 1'b1;
        wait_mtip();
        read_csr(CSR_ADDR_MIP, 32'h80);
        ready_next = 1'b1;
        expect_tv(base + 32'd28);
        send_cmd(CSR_X, 12'h000, '0, CSR_ECALL, '0);
        irq_armed <= 1'b0;
        m_mcause = `CSR_CAUSE_M_TIMER;
        m_mepc   = pc;
        m_mpp    = m_mode;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
        read_csr(CSR_ADDR_MCAUSE, m_mcause);
        read_csr(CSR_ADDR_MEPC, m_mepc);
        read_csr(CSR_ADDR_MSTATUS, mstatus_model());
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the command count
    initial begin
        #(RUN_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Watchdog expired at %0t, tests did not complete", $time);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
+incdir+verif
common/csr_pkg.sv
common/csr_req_if.sv
common/trap_evt_if.sv
source/csr_decode.sv
csr_file/csr_regs.sv
csr_file/trap_ctrl.sv
source/csr_result.sv
source/csr_stage.sv
verif/tb_csr_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CSR stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f tb.f --top-module tb_csr_stage -o tb_csr_stage --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_csr_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -Fxq "Done: no errors" "$LOG"; then
    exit 0
fi
exit 1
